/* Makefile */
TOOL    = verilator
TOP     = tb_spi_reg_top
FLIST   = flist.f
OBJ_DIR = obj_dir
LOG     = sim.log
FLAGS   = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/spi_master_tasks.svh */
// spi master helpers: crc-8 reference, frame packing, bit-banged transfer with miso capture

// ========================================
// crc-8 reference model
// ========================================
// remainder of {msg, 8'h00} divided by x^8 + x^2 + x + 1
function automatic logic [7:0] crc8_ref(input logic [15:0] msg);
    logic [23:0] rem;
    rem = {msg, 8'h00};
    for (int i = 23; i >= 8; i--) begin
        if (rem[i]) begin
            rem[i -: 9] = rem[i -: 9] ^ {1'b1, spi_frame_pkg::CRC_POLY};
        end
    end
    return rem[7:0];
endfunction

// frame and response share one layout: {wr, addr, data, crc}
function automatic logic [spi_frame_pkg::FRM_BIT_NUM-1:0] pack_frame(
    input logic       wr,
    input logic [6:0] addr,
    input logic [7:0] data
);
    return {wr, addr, data, crc8_ref({wr, addr, data})};
endfunction

// ========================================
// spi mode 3 transfer
// ========================================
// call on a falling core clock edge; sclk idles high
task automatic shift_frame(
    input  logic [spi_frame_pkg::FRM_BIT_NUM-1:0] mosi_word,
    input  int                                    half_cyc,
    output logic [spi_frame_pkg::FRM_BIT_NUM-1:0] miso_word
);
    miso_word = '0;
    i_spi_csb = 1'b0;
    repeat (half_cyc) @(negedge i_clk);
    for (int i = spi_frame_pkg::FRM_BIT_NUM - 1; i >= 0; i--) begin
        i_spi_sclk = 1'b0;
        i_spi_mosi = mosi_word[i];
        repeat (half_cyc) @(negedge i_clk);
        // miso has been stable since the falling edge
        miso_word[i] = o_spi_miso;
        i_spi_sclk   = 1'b1;
        repeat (half_cyc) @(negedge i_clk);
    end
    i_spi_csb  = 1'b1;
    i_spi_mosi = 1'b0;
endtask

/* bench/tb_spi_reg_top.sv */
// testbench for spi_reg_top: clock, reset, frame sequence, register model and checks
`timescale 1ns/10ps

module tb_spi_reg_top;

    // core clock period in ns
    localparam int CLK_PER     = 1000 / reg_map_pkg::CLK_M;
    // 8 core cycles per sclk bit
    localparam int HALF_SLOW   = 4;
    localparam int HALF_FAST   = 1;
    localparam int ACC_WIN_CYC = 10;
    localparam int GAP_CYC     = reg_map_pkg::MIN_ACC_GAP_CYC;
    localparam int NUM_FRAMES  = 15;
    // lead-in and bits, access window, idle gap
    localparam int FRAME_CYC   = 2 * HALF_SLOW * (spi_frame_pkg::FRM_BIT_NUM + 1)
                               + ACC_WIN_CYC + GAP_CYC;
    localparam int CYC_LIMIT   = (NUM_FRAMES + 2) * FRAME_CYC;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_spi_sclk;
    logic        i_spi_csb;
    logic        i_spi_mosi;
    logic        i_spi_slv_en;
    logic        o_spi_miso;
    logic        o_spi_err;

    logic [31:0] rng_state;
    logic [7:0]  model_regs [reg_map_pkg::REG_NUM];
    logic [23:0] exp_rsp;
    logic        err_window;
    int          cycle_cnt;

    spi_reg_top spi_reg_top_inst (
        .i_spi_sclk   (i_spi_sclk),
        .i_spi_csb    (i_spi_csb),
        .i_spi_mosi   (i_spi_mosi),
        .i_spi_slv_en (i_spi_slv_en),
        .o_spi_miso   (o_spi_miso),
        .o_spi_err    (o_spi_err),
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n)
    );

    `include "spi_master_tasks.svh"

    always #(CLK_PER / 2) i_clk = ~i_clk;

    // ========================================
    // failure reporting
    // ========================================
    task automatic stop_with_fail();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp_v, got_v);
        stop_with_fail();
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        stop_with_fail();
    endtask

    always @(posedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYC_LIMIT) begin
            report_failure("timeout, the frame sequence did not finish");
        end
    end

    // error flag is a single-cycle pulse
    a_err_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_spi_err |=> !o_spi_err)
        else report_failure("o_spi_err stayed high for more than one cycle");

    a_err_window: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_spi_err |-> err_window)
        else report_failure("o_spi_err pulsed for a frame that should be accepted");

    a_miso_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_spi_csb |-> !o_spi_miso)
        else report_failure("o_spi_miso not low while chip select is high");

    // ========================================
    // stimulus and model
    // ========================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_byte(output logic [7:0] b);
        rng_state = xorshift32(rng_state);
        b = rng_state[7:0];
    endtask

    task automatic update_model(input logic wr, input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] rd_val;
        if (wr) begin
            if (addr < reg_map_pkg::REG_NUM) begin
                model_regs[addr[3:0]] = data;
            end
            exp_rsp = pack_frame(1'b1, addr, data);
        end else begin
            rd_val = (addr < reg_map_pkg::REG_NUM) ? model_regs[addr[3:0]] : 8'h00;
            exp_rsp = pack_frame(1'b0, addr, rd_val);
        end
    endtask

    task automatic watch_access(output logic err_seen);
        err_seen = 1'b0;
        repeat (ACC_WIN_CYC) begin
            @(negedge i_clk);
            if (o_spi_err) begin
                err_seen = 1'b1;
            end
        end
    endtask

    // one frame; miso carries the response of the previous accepted access
    task automatic run_frame(input logic wr, input logic [6:0] addr, input logic [7:0] data,
                             input int half_cyc, input logic bad_crc, input logic exp_err,
                             input int gap_cyc);
        logic [23:0] mosi_word;
        logic [23:0] miso_word;
        logic [23:0] prev_rsp;
        logic        err_seen;
        mosi_word = pack_frame(wr, addr, data);
        if (bad_crc) begin
            mosi_word[7:0] = ~mosi_word[7:0];
        end
        prev_rsp   = exp_rsp;
        err_window = exp_err;
        shift_frame(mosi_word, half_cyc, miso_word);
        watch_access(err_seen);
        err_window = 1'b0;
        assert (miso_word[23] == prev_rsp[23])
            else report_mismatch("o_spi_miso status bit", prev_rsp[23], miso_word[23]);
        assert (miso_word[22:16] == prev_rsp[22:16])
            else report_mismatch("o_spi_miso addr field", prev_rsp[22:16], miso_word[22:16]);
        assert (miso_word[15:8] == prev_rsp[15:8])
            else report_mismatch("o_spi_miso data field", prev_rsp[15:8], miso_word[15:8]);
        assert (miso_word[7:0] == prev_rsp[7:0])
            else report_mismatch("o_spi_miso crc field", prev_rsp[7:0], miso_word[7:0]);
        assert (err_seen == exp_err)
            else report_mismatch("o_spi_err", exp_err, err_seen);
        if (!exp_err && i_spi_slv_en) begin
            update_model(wr, addr, data);
        end
        repeat (gap_cyc) @(negedge i_clk);
    endtask

    initial begin
        logic [7:0] rnd;
        logic [6:0] a0, a1, a2;
        logic [7:0] d0, d1, d2, dx;
        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_spi_sclk   = 1'b1;
        i_spi_csb    = 1'b0;
        i_spi_mosi   = 1'b0;
        i_spi_slv_en = 1'b1;
        rng_state    = 32'h92c5d157;
        exp_rsp      = '0;
        err_window   = 1'b0;
        cycle_cnt    = 0;
        for (int i = 0; i < reg_map_pkg::REG_NUM; i++) begin
            model_regs[i] = 8'h00;
        end
        @(negedge i_clk);
        // deselect edge parks the miso pointer
        i_spi_csb = 1'b1;
        @(negedge i_clk);
        i_rst_n = 1'b1;

        next_byte(rnd);
        a0 = {3'b000, rnd[3:0]};
        a1 = {3'b000, rnd[3:0] + 4'd5};
        a2 = {3'b000, rnd[3:0] + 4'd11};
        next_byte(d0);
        next_byte(d1);
        next_byte(d2);
        next_byte(dx);

        // writes, then reads of the same registers
        run_frame(1'b1, a0, d0, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        run_frame(1'b1, a1, d1, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        run_frame(1'b1, a2, d2, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        run_frame(1'b0, a0, 8'h00, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        run_frame(1'b0, a1, 8'h00, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        run_frame(1'b0, a2, 8'h00, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        // corrupted crc byte, register must keep d0
        run_frame(1'b1, a0, ~d0, HALF_SLOW, 1'b1, 1'b1, GAP_CYC);
        run_frame(1'b0, a0, 8'h00, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        // fast second write lands inside the access gap
        run_frame(1'b1, a1, dx, HALF_SLOW, 1'b0, 1'b0, 0);
        run_frame(1'b1, a1, ~dx, HALF_FAST, 1'b0, 1'b1, GAP_CYC);
        // slave disabled: no access, no error, response kept
        i_spi_slv_en = 1'b0;
        run_frame(1'b1, a2, ~d2, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        i_spi_slv_en = 1'b1;
        run_frame(1'b0, a1, 8'h00, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        run_frame(1'b0, a2, 8'h00, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        // address outside the bank reads zero
        run_frame(1'b0, 7'h5a, 8'h00, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);
        run_frame(1'b0, a0, 8'h00, HALF_SLOW, 1'b0, 1'b0, GAP_CYC);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* flist.f */
hdl/spi_frame_pkg.sv
hdl/reg_map_pkg.sv
hdl/gnrl_sync.sv
hdl/crc8_calc.sv
hdl/spi_slv.sv
hdl/reg_access_ctrl.sv
hdl/spi_reg_top.sv
+incdir+bench
bench/tb_spi_reg_top.sv

/* hdl/crc8_calc.sv */
// combinational crc-8 over a 16-bit word, serial algorithm unrolled
`timescale 1ns/10ps

module crc8_calc (
    input  logic [spi_frame_pkg::FRM_CHK_W-1:0] i_data,
    output logic [spi_frame_pkg::FRM_CRC_W-1:0] o_crc
);

    logic [spi_frame_pkg::FRM_CRC_W-1:0] crc_acc;

    // one lfsr step per input bit, msb first, zero seed
    always_comb begin
        crc_acc = '0;
        for (int i = spi_frame_pkg::FRM_CHK_W - 1; i >= 0; i--) begin
            if (crc_acc[spi_frame_pkg::FRM_CRC_W-1] ^ i_data[i]) begin
                crc_acc = {crc_acc[spi_frame_pkg::FRM_CRC_W-2:0], 1'b0}
                        ^ spi_frame_pkg::CRC_POLY;
            end else begin
                crc_acc = {crc_acc[spi_frame_pkg::FRM_CRC_W-2:0], 1'b0};
            end
        end
        o_crc = crc_acc;
    end

endmodule

/* hdl/gnrl_sync.sv */
// two-flop synchronizer with configurable width and reset value
`timescale 1ns/10ps

module gnrl_sync #(
    parameter int              DW      = 1,
    parameter logic [DW-1:0]   RST_VAL = '0
) (
    input  logic [DW-1:0] i_data,
    output logic [DW-1:0] o_data,
    input  logic          i_clk,
    input  logic          i_rst_n
);

    // first stage may go metastable
    logic [DW-1:0] meta_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            meta_q <= RST_VAL;
            o_data <= RST_VAL;
        end else begin
            meta_q <= i_data;
            o_data <= meta_q;
        end
    end

endmodule

/* hdl/reg_access_ctrl.sv */
// register access controller: 16-entry bank, one ack per request, read return
`timescale 1ns/10ps

module reg_access_ctrl (
    input  logic                           i_wr_req,
    input  logic                           i_rd_req,
    input  logic [reg_map_pkg::REG_AW-1:0] i_addr,
    input  logic [reg_map_pkg::REG_DW-1:0] i_wdata,
    output logic                           o_wack,
    output logic                           o_rack,
    output logic [reg_map_pkg::REG_DW-1:0] o_rdata,
    output logic [reg_map_pkg::REG_AW-1:0] o_addr,
    input  logic                           i_clk,
    input  logic                           i_rst_n
);

    logic [reg_map_pkg::REG_DW-1:0]          reg_bank [reg_map_pkg::REG_NUM];
    logic [$clog2(reg_map_pkg::REG_NUM)-1:0] bank_idx;
    logic                                    addr_hit;
    logic                                    served;
    logic                                    wr_go;
    logic                                    rd_go;

    assign addr_hit = (i_addr < reg_map_pkg::REG_NUM);
    assign bank_idx = i_addr[$clog2(reg_map_pkg::REG_NUM)-1:0];

    // write wins if both were ever raised
    assign wr_go = i_wr_req & ~served;
    assign rd_go = i_rd_req & ~i_wr_req & ~served;

    // held request seen last cycle, so it is not served twice
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            served <= 1'b0;
        end else begin
            served <= i_wr_req | i_rd_req;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wack <= 1'b0;
            o_rack <= 1'b0;
        end else begin
            o_wack <= wr_go;
            o_rack <= rd_go;
        end
    end

    // ========================================
    // register bank
    // ========================================
    // writes outside the bank are dropped
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < reg_map_pkg::REG_NUM; i++) begin
                reg_bank[i] <= '0;
            end
        end else if (wr_go && addr_hit) begin
            reg_bank[bank_idx] <= i_wdata;
        end
    end

    // returned with the ack: written value, bank value, or zero
    always_ff @(posedge i_clk) begin
        if (wr_go) begin
            o_rdata <= i_wdata;
            o_addr  <= i_addr;
        end else if (rd_go) begin
            o_rdata <= addr_hit ? reg_bank[bank_idx] : '0;
            o_addr  <= i_addr;
        end
    end

    // ack pulse lands while the slave still holds the request
    a_wack_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wack |-> i_wr_req);
    a_rack_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rack |-> i_rd_req);

endmodule

/* hdl/reg_map_pkg.sv */
// register bank geometry, core clock rate and access gap limit
package reg_map_pkg;

    // ========================================
    // register bank
    // ========================================
    localparam int REG_AW  = 7;
    localparam int REG_DW  = 8;
    // only the lowest addresses are backed by flops
    localparam int REG_NUM = 16;

    // ========================================
    // core timing
    // ========================================
    // core clock in MHz
    localparam int CLK_M = 25;

    // core cycles required after an acknowledge before the next launch,
    // kept short here so simulation runs quickly
    localparam int MIN_ACC_GAP_CYC = 64;
    localparam int ACC_GAP_CNT_W   = $clog2(MIN_ACC_GAP_CYC + 1);

endpackage

/* hdl/spi_frame_pkg.sv */
// spi frame field widths, crc-8 generator and response layout constants
package spi_frame_pkg;

    // ========================================
    // frame fields, sent MSB first
    // ========================================
    // command byte: bit 7 write flag, bits 6..0 register address
    localparam int FRM_CMD_W   = 8;
    localparam int FRM_DATA_W  = 8;
    localparam int FRM_CRC_W   = 8;
    // crc covers command and data
    localparam int FRM_CHK_W   = FRM_CMD_W + FRM_DATA_W;
    localparam int FRM_BIT_NUM = FRM_CMD_W + FRM_DATA_W + FRM_CRC_W;

    // pointer over {response, received} cache, 48 bits
    localparam int MISO_PTR_W  = $clog2(2 * FRM_BIT_NUM);

    // ========================================
    // crc and response layout
    // ========================================
    // x^8 + x^2 + x + 1, zero init, msb first
    localparam logic [FRM_CRC_W-1:0] CRC_POLY = 8'h07;

    // response: {wr flag, addr[6:0], data[7:0], crc[7:0]}
    localparam int RSP_WR_FLAG_POS = FRM_BIT_NUM - 1;

endpackage

/* hdl/spi_reg_top.sv */
// top level: spi slave joined to the register access controller
`timescale 1ns/10ps

module spi_reg_top (
    input  logic i_spi_sclk,
    input  logic i_spi_csb,
    input  logic i_spi_mosi,
    input  logic i_spi_slv_en,
    output logic o_spi_miso,
    output logic o_spi_err,
    input  logic i_clk,
    input  logic i_rst_n
);

    // slave to controller
    logic                           rac_wr_req;
    logic                           rac_rd_req;
    logic [reg_map_pkg::REG_AW-1:0] rac_addr;
    logic [reg_map_pkg::REG_DW-1:0] rac_wdata;
    // controller back to slave
    logic                           rac_wack;
    logic                           rac_rack;
    logic [reg_map_pkg::REG_DW-1:0] rac_rdata;
    logic [reg_map_pkg::REG_AW-1:0] rac_rsp_addr;

    spi_slv u_spi_slv (
        .i_spi_sclk   (i_spi_sclk),
        .i_spi_csb    (i_spi_csb),
        .i_spi_mosi   (i_spi_mosi),
        .o_spi_miso   (o_spi_miso),
        .i_spi_slv_en (i_spi_slv_en),
        .o_rac_wr_req (rac_wr_req),
        .o_rac_rd_req (rac_rd_req),
        .o_rac_addr   (rac_addr),
        .o_rac_wdata  (rac_wdata),
        .i_rac_wack   (rac_wack),
        .i_rac_rack   (rac_rack),
        .i_rac_rdata  (rac_rdata),
        .i_rac_addr   (rac_rsp_addr),
        .o_spi_err    (o_spi_err),
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n)
    );

    reg_access_ctrl u_reg_access_ctrl (
        .i_wr_req (rac_wr_req),
        .i_rd_req (rac_rd_req),
        .i_addr   (rac_addr),
        .i_wdata  (rac_wdata),
        .o_wack   (rac_wack),
        .o_rack   (rac_rack),
        .o_rdata  (rac_rdata),
        .o_addr   (rac_rsp_addr),
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n)
    );

endmodule

/* hdl/spi_slv.sv */
// spi mode 3 slave: frame capture, miso response, access launch and checks
`timescale 1ns/10ps

module spi_slv (
    input  logic                           i_spi_sclk,
    // active low
    input  logic                           i_spi_csb,
    input  logic                           i_spi_mosi,
    output logic                           o_spi_miso,
    input  logic                           i_spi_slv_en,
    // request side to the register access controller
    output logic                           o_rac_wr_req,
    output logic                           o_rac_rd_req,
    output logic [reg_map_pkg::REG_AW-1:0] o_rac_addr,
    output logic [reg_map_pkg::REG_DW-1:0] o_rac_wdata,
    // acknowledge side
    input  logic                           i_rac_wack,
    input  logic                           i_rac_rack,
    input  logic [reg_map_pkg::REG_DW-1:0] i_rac_rdata,
    input  logic [reg_map_pkg::REG_AW-1:0] i_rac_addr,
    output logic                           o_spi_err,
    input  logic                           i_clk,
    input  logic                           i_rst_n
);

    logic [spi_frame_pkg::FRM_BIT_NUM-1:0]   rx_shift;
    logic [spi_frame_pkg::FRM_BIT_NUM-1:0]   slv_rsp;
    logic [2*spi_frame_pkg::FRM_BIT_NUM-1:0] miso_cache;
    logic [spi_frame_pkg::MISO_PTR_W-1:0]    miso_ptr;
    logic                                    csb_sync;
    logic                                    csb_sync_q;
    logic                                    launch;
    logic [spi_frame_pkg::FRM_CMD_W-1:0]     rx_cmd;
    logic [spi_frame_pkg::FRM_DATA_W-1:0]    rx_data;
    logic [spi_frame_pkg::FRM_CRC_W-1:0]     rx_crc;
    logic [spi_frame_pkg::FRM_CHK_W-1:0]     rsp_chk;
    logic [spi_frame_pkg::FRM_CHK_W-1:0]     crc_in;
    logic [spi_frame_pkg::FRM_CRC_W-1:0]     crc_out;
    logic                                    crc_err;
    logic                                    gap_err;
    logic                                    spi_err;
    logic                                    wr_launch;
    logic                                    rd_launch;
    logic                                    rac_ack;
    logic [2:0]                              ack_d;
    logic                                    acc_busy;
    logic [reg_map_pkg::ACC_GAP_CNT_W-1:0]   gap_cnt;

    // ========================================
    // sclk domain
    // ========================================
    // mosi sampled on rising edge, frame kept after cs rises
    always_ff @(posedge i_spi_sclk) begin
        if (!i_spi_csb) begin
            rx_shift <= {rx_shift[spi_frame_pkg::FRM_BIT_NUM-2:0], i_spi_mosi};
        end
    end

    // response goes out first, then the received bits echo back
    assign miso_cache = {slv_rsp, rx_shift};

    always_ff @(negedge i_spi_sclk or posedge i_spi_csb) begin
        if (i_spi_csb) begin
            miso_ptr <= spi_frame_pkg::MISO_PTR_W'(2 * spi_frame_pkg::FRM_BIT_NUM - 1);
        end else if (miso_ptr == '0) begin
            miso_ptr <= spi_frame_pkg::MISO_PTR_W'(2 * spi_frame_pkg::FRM_BIT_NUM - 1);
        end else begin
            miso_ptr <= miso_ptr - 1'b1;
        end
    end

    // miso changes on falling edge, parked low while deselected
    always_ff @(negedge i_spi_sclk or posedge i_spi_csb) begin
        if (i_spi_csb) begin
            o_spi_miso <= 1'b0;
        end else begin
            o_spi_miso <= miso_cache[miso_ptr];
        end
    end

    // ========================================
    // chip select edge into core domain
    // ========================================
    gnrl_sync #(
        .DW      (1),
        .RST_VAL (1'b1)
    ) u_csb_sync (
        .i_data  (i_spi_csb),
        .o_data  (csb_sync),
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            csb_sync_q <= 1'b1;
        end else begin
            csb_sync_q <= csb_sync;
        end
    end

    // frames arriving during an access are dropped
    assign launch = csb_sync & ~csb_sync_q & i_spi_slv_en & ~acc_busy;

    // ========================================
    // frame checks
    // ========================================
    assign rx_cmd  = rx_shift[spi_frame_pkg::FRM_BIT_NUM-1 -: spi_frame_pkg::FRM_CMD_W];
    assign rx_data = rx_shift[spi_frame_pkg::FRM_CRC_W +: spi_frame_pkg::FRM_DATA_W];
    assign rx_crc  = rx_shift[spi_frame_pkg::FRM_CRC_W-1:0];

    assign rac_ack = i_rac_wack | i_rac_rack;
    assign rsp_chk = {i_rac_wack, i_rac_addr, i_rac_rdata};

    // shared crc: response on ack, received frame otherwise
    assign crc_in = rac_ack ? rsp_chk : {rx_cmd, rx_data};

    crc8_calc u_crc (
        .i_data (crc_in),
        .o_crc  (crc_out)
    );

    // also catches a frame that was not a multiple of 24 clocks
    assign crc_err = launch & (crc_out != rx_crc);

    // ack history, busy drops once the response has settled
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_d <= '0;
        end else begin
            ack_d <= {ack_d[1:0], rac_ack};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_busy <= 1'b0;
        end else if (ack_d[2]) begin
            acc_busy <= 1'b0;
        end else if (wr_launch | rd_launch) begin
            acc_busy <= 1'b1;
        end
    end

    // cycles since last ack, saturating; starts past the limit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gap_cnt <= '1;
        end else if (rac_ack) begin
            gap_cnt <= '0;
        end else if (gap_cnt < reg_map_pkg::MIN_ACC_GAP_CYC) begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    assign gap_err = launch & (gap_cnt < reg_map_pkg::MIN_ACC_GAP_CYC);
    assign spi_err = crc_err | gap_err;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_spi_err <= 1'b0;
        end else begin
            o_spi_err <= spi_err;
        end
    end

    // ========================================
    // request generation
    // ========================================
    assign wr_launch = launch &  rx_cmd[spi_frame_pkg::FRM_CMD_W-1] & ~spi_err;
    assign rd_launch = launch & ~rx_cmd[spi_frame_pkg::FRM_CMD_W-1] & ~spi_err;

    // level request, cleared by the ack pulse
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rac_wr_req <= 1'b0;
            o_rac_rd_req <= 1'b0;
        end else begin
            o_rac_wr_req <= i_rac_wack ? 1'b0 : (wr_launch | o_rac_wr_req);
            o_rac_rd_req <= i_rac_rack ? 1'b0 : (rd_launch | o_rac_rd_req);
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_launch | rd_launch) begin
            o_rac_addr <= rx_cmd[spi_frame_pkg::FRM_CMD_W-2:0];
        end
        if (wr_launch) begin
            o_rac_wdata <= rx_data;
        end
    end

    // ========================================
    // response register
    // ========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            slv_rsp <= '0;
        end else if (rac_ack) begin
            slv_rsp[spi_frame_pkg::RSP_WR_FLAG_POS] <= i_rac_wack;
            slv_rsp[spi_frame_pkg::RSP_WR_FLAG_POS-1 -: reg_map_pkg::REG_AW] <= i_rac_addr;
            slv_rsp[spi_frame_pkg::FRM_CRC_W +: reg_map_pkg::REG_DW] <= i_rac_rdata;
            slv_rsp[spi_frame_pkg::FRM_CRC_W-1:0] <= crc_out;
        end
    end

    // one access at a time toward the controller
    a_req_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_rac_wr_req && o_rac_rd_req));

    // a rejected frame never also issues a request
    a_err_no_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !($rose(o_spi_err) && ($rose(o_rac_wr_req) || $rose(o_rac_rd_req))));

endmodule
